// ==== hit_trg_count.f ====
design/monit_cfg_pkg.sv
design/monit_types_pkg.sv
design/pulse_mon_if.sv
design/edge_event_counters.sv
design/pulse_width_monitor.sv
design/sat_err_counter.sv
design/hit_monit_group.sv
design/tmr_event_counter.sv
design/hit_trg_count.sv
bench/hit_trg_count_sva.sv
bench/tb_hit_trg_count.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_hit_trg_count
FLIST     ?= hit_trg_count.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= TEST PASSED

SRCS := $(filter-out +%,$(shell cat $(FLIST)))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM)
	$(SIM) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/tb_hit_trg_count.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_hit_trg_count;

	localparam int NUM_TRANS      = 300;                   // random transactions
	localparam int TIMEOUT_CYCLES = NUM_TRANS * 20 + 1000; // longest pulse plus gap, with margin
	localparam int HIT_W          = monit_cfg_pkg::HIT_WIDTH;
	localparam int BUSY_W         = monit_cfg_pkg::BUSY_WIDTH;
	localparam int EDGE_LEN [4]   = '{HIT_W - 1, HIT_W, HIT_W + 3, HIT_W + 4}; // window edges

	logic                               clk_in;
	logic                               rst_in;
	logic [monit_cfg_pkg::NUM_HIT-1:0]  hit_syn;
	logic [monit_cfg_pkg::NUM_BUSY-1:0] busy_syn;
	logic                               hit_start;
	logic                               update_end;
	logic                               eff_trg;
	logic                               coincid_trg;
	logic                               logic_match;
	logic                               ext_trg_syn;
	monit_types_pkg::hit_sel_t          hit_monit_fix_sel;
	monit_types_pkg::busy_sel_t         busy_monit_fix_sel;
	monit_types_pkg::hit_sel_t          hit_monit_sel;
	monit_types_pkg::err_cnt_t          hit_monit_err_cnt;
	monit_types_pkg::err_cnt_t          busy_monit_err_cnt;
	monit_types_pkg::rate_cnt_t         hit_monit_cnt_0;
	monit_types_pkg::rate_cnt_t         hit_monit_cnt_1;
	monit_types_pkg::evt_cnt_t          busy_monit_cnt;
	monit_types_pkg::evt_cnt_t          hit_start_cnt;
	monit_types_pkg::evt_cnt_t          logic_match_cnt;
	monit_types_pkg::evt_cnt_t          eff_trg_cnt;
	monit_types_pkg::evt_cnt_t          coincid_trg_cnt;
	monit_types_pkg::evt_cnt_t          ext_trg_cnt;

	int                         seed        = 80334;
	int                         cycle_cnt   = 0;
	int                         err_count   = 0;
	int                         check_count = 0;
	monit_types_pkg::evt_cnt_t  exp_evt [4] = '{default: '0}; // hit start, coincid, match, ext
	monit_types_pkg::evt_cnt_t  exp_eff      = '0;
	monit_types_pkg::rate_cnt_t exp_cnt_0    = '0;
	monit_types_pkg::rate_cnt_t exp_cnt_1    = '0;
	monit_types_pkg::evt_cnt_t  exp_busy_cnt = '0;
	monit_types_pkg::err_cnt_t  exp_hit_err  = '0;
	monit_types_pkg::err_cnt_t  exp_busy_err = '0;
	monit_types_pkg::hit_sel_t  exp_sel      = '0;
	int                         fix_hit;
	int                         fix_busy;

	hit_trg_count i_dut (
		.clk_in             (clk_in),
		.rst_in             (rst_in),
		.hit_syn            (hit_syn),
		.busy_syn           (busy_syn),
		.hit_start          (hit_start),
		.update_end         (update_end),
		.eff_trg            (eff_trg),
		.coincid_trg        (coincid_trg),
		.logic_match        (logic_match),
		.ext_trg_syn        (ext_trg_syn),
		.hit_monit_fix_sel  (hit_monit_fix_sel),
		.busy_monit_fix_sel (busy_monit_fix_sel),
		.hit_monit_sel      (hit_monit_sel),
		.hit_monit_err_cnt  (hit_monit_err_cnt),
		.busy_monit_err_cnt (busy_monit_err_cnt),
		.hit_monit_cnt_0    (hit_monit_cnt_0),
		.hit_monit_cnt_1    (hit_monit_cnt_1),
		.busy_monit_cnt     (busy_monit_cnt),
		.hit_start_cnt      (hit_start_cnt),
		.logic_match_cnt    (logic_match_cnt),
		.eff_trg_cnt        (eff_trg_cnt),
		.coincid_trg_cnt    (coincid_trg_cnt),
		.ext_trg_cnt        (ext_trg_cnt)
	);

	initial begin
		clk_in = 1'b0;
		forever #10 clk_in = ~clk_in; // 50 MHz
	end

	initial begin
		while (cycle_cnt < TIMEOUT_CYCLES) begin
			@(posedge clk_in);
			cycle_cnt++;
		end
		$display("timeout: stimulus still running after %0d cycles", TIMEOUT_CYCLES);
		$display("TEST FAILED");
		$finish;
	end

	function automatic int rand_range(input int lo, input int hi);
		return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
	endfunction

	function automatic monit_types_pkg::err_cnt_t saturate_inc(input monit_types_pkg::err_cnt_t v);
		return (v == '1) ? v : v + 1'b1; // error counters stop at 255
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		check_count++;
		if (got !== exp) begin
			err_count++;
			$display("ERR %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic verify_outputs();
		@(negedge clk_in); // outputs settled mid cycle
		check_value("hit_start_cnt", 32'(hit_start_cnt), 32'(exp_evt[0]));
		check_value("coincid_trg_cnt", 32'(coincid_trg_cnt), 32'(exp_evt[1]));
		check_value("logic_match_cnt", 32'(logic_match_cnt), 32'(exp_evt[2]));
		check_value("ext_trg_cnt", 32'(ext_trg_cnt), 32'(exp_evt[3]));
		check_value("eff_trg_cnt", 32'(eff_trg_cnt), 32'(exp_eff));
		check_value("hit_monit_cnt_0", hit_monit_cnt_0, exp_cnt_0);
		check_value("hit_monit_cnt_1", hit_monit_cnt_1, exp_cnt_1);
		check_value("busy_monit_cnt", 32'(busy_monit_cnt), 32'(exp_busy_cnt));
		check_value("hit_monit_sel", 32'(hit_monit_sel), 32'(exp_sel));
		check_value("hit_monit_err_cnt", 32'(hit_monit_err_cnt), 32'(exp_hit_err));
		check_value("busy_monit_err_cnt", 32'(busy_monit_err_cnt), 32'(exp_busy_err));
	endtask

	task automatic wait_idle(input int n);
		repeat (n) @(posedge clk_in);
	endtask

	task automatic send_line_pulse(input bit busy_line, input int line, input int len);
		int width;
		bit bad;
		width = busy_line ? BUSY_W : HIT_W;
		bad   = (len < width) || (len > width + 3); // good window is W to W+3
		@(posedge clk_in);
		if (busy_line) begin
			busy_syn <= 2'b01 << line;
		end else begin
			hit_syn <= 8'h01 << line;
		end
		repeat (len) @(posedge clk_in); // len high cycles
		hit_syn  <= '0;
		busy_syn <= '0;
		if (busy_line) begin
			if (line == fix_busy) begin
				exp_busy_cnt = exp_busy_cnt + 1'b1;
				exp_busy_err = bad ? saturate_inc(exp_busy_err) : exp_busy_err;
			end
		end else begin
			if (line == fix_hit) begin
				exp_cnt_0 = exp_cnt_0 + 1'b1;
			end
			if (line == int'(exp_sel)) begin
				exp_cnt_1 = exp_cnt_1 + 1'b1;
			end
			if (bad && (line == fix_hit || line == int'(exp_sel))) begin
				exp_hit_err = saturate_inc(exp_hit_err); // both monitors count once
			end
		end
	endtask

	task automatic pulse_event(input int which, input int len);
		@(posedge clk_in);
		case (which)
			0: hit_start <= 1'b1;
			1: coincid_trg <= 1'b1;
			2: logic_match <= 1'b1;
			default: ext_trg_syn <= 1'b1;
		endcase
		repeat (len) @(posedge clk_in);
		hit_start   <= 1'b0;
		coincid_trg <= 1'b0;
		logic_match <= 1'b0;
		ext_trg_syn <= 1'b0;
		exp_evt[which] = exp_evt[which] + 1'b1; // one rise whatever the length
	endtask

	task automatic burst_eff_trg(input int len);
		@(posedge clk_in);
		eff_trg <= 1'b1;
		repeat (len) @(posedge clk_in);
		eff_trg <= 1'b0;
		exp_eff = exp_eff + 16'(len); // level count, every high cycle
	endtask

	task automatic strobe_update_end(input int len, input int new_hit, input int new_busy);
		@(posedge clk_in);
		update_end         <= 1'b1;
		hit_monit_fix_sel  <= monit_types_pkg::hit_sel_t'(new_hit); // lines idle, safe to move
		busy_monit_fix_sel <= monit_types_pkg::busy_sel_t'(new_busy);
		repeat (len) @(posedge clk_in);
		update_end <= 1'b0;
		exp_cnt_0    = '0; // window restarts
		exp_cnt_1    = '0;
		exp_busy_cnt = '0;
		exp_hit_err  = '0;
		exp_busy_err = '0;
		exp_sel      = exp_sel + 1'b1; // one step per strobe, wraps after 7
		fix_hit      = new_hit;
		fix_busy     = new_busy;
	endtask

	initial begin
		int kind;
		int pick;
		int line;
		int len;
		bit is_busy;
		fix_hit            = rand_range(0, 7);
		fix_busy           = rand_range(0, 1);
		rst_in             = 1'b1;
		hit_syn            = '0;
		busy_syn           = '0;
		hit_start          = 1'b0;
		update_end         = 1'b0;
		eff_trg            = 1'b0;
		coincid_trg        = 1'b0;
		logic_match        = 1'b0;
		ext_trg_syn        = 1'b0;
		hit_monit_fix_sel  = monit_types_pkg::hit_sel_t'(fix_hit);
		busy_monit_fix_sel = monit_types_pkg::busy_sel_t'(fix_busy);
		repeat (10) @(posedge clk_in);
		rst_in <= 1'b0;
		verify_outputs(); // everything zero out of reset
		for (int t = 0; t < NUM_TRANS; t++) begin
			kind = rand_range(0, 5);
			case (kind)
				0, 1, 2: begin
					is_busy = (rand_range(0, 3) == 0);
					pick    = rand_range(0, 2); // favour the watched lines
					if (is_busy) begin
						line = (pick == 0) ? fix_busy : rand_range(0, 1);
					end else if (pick == 0) begin
						line = fix_hit;
					end else if (pick == 1) begin
						line = int'(exp_sel);
					end else begin
						line = rand_range(0, 7);
					end
					if (rand_range(0, 1) == 0) begin
						len = EDGE_LEN[rand_range(0, 3)];
					end else begin
						len = rand_range(4, 14);
					end
					send_line_pulse(is_busy, line, len);
				end
				3: begin
					pick = rand_range(0, 3);
					len  = rand_range(1, 4);
					pulse_event(pick, len);
				end
				4: burst_eff_trg(rand_range(1, 8));
				default: begin
					len  = rand_range(1, 3);
					pick = rand_range(0, 7);
					line = rand_range(0, 1);
					strobe_update_end(len, pick, line);
				end
			endcase
			wait_idle(rand_range(3, 5)); // covers the two-edge trigger latency
			verify_outputs();
		end
		$display("checks: %0d, errors: %0d", check_count, err_count);
		if (err_count == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule : tb_hit_trg_count

`default_nettype wire

// ==== bench/hit_trg_count_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module hit_trg_count_sva (
	input wire logic                       clk_in,
	input wire logic                       rst_in,
	input wire logic                       update_end,
	input wire logic                       update_rise,
	input wire monit_types_pkg::hit_sel_t  hit_monit_sel,
	input wire monit_types_pkg::err_cnt_t  hit_monit_err_cnt,
	input wire monit_types_pkg::err_cnt_t  busy_monit_err_cnt,
	input wire monit_types_pkg::rate_cnt_t hit_monit_cnt_0,
	input wire monit_types_pkg::rate_cnt_t hit_monit_cnt_1,
	input wire monit_types_pkg::evt_cnt_t  busy_monit_cnt,
	input wire monit_types_pkg::evt_cnt_t  hit_start_cnt,
	input wire monit_types_pkg::evt_cnt_t  logic_match_cnt,
	input wire monit_types_pkg::evt_cnt_t  eff_trg_cnt,
	input wire monit_types_pkg::evt_cnt_t  coincid_trg_cnt,
	input wire monit_types_pkg::evt_cnt_t  ext_trg_cnt
);
	// all counters and the selector read zero the cycle after reset
	assert property (@(posedge clk_in) rst_in |=>
		(hit_monit_sel == '0 && hit_monit_err_cnt == '0 && busy_monit_err_cnt == '0
		&& hit_monit_cnt_0 == '0 && hit_monit_cnt_1 == '0 && busy_monit_cnt == '0
		&& hit_start_cnt == '0 && logic_match_cnt == '0 && eff_trg_cnt == '0
		&& coincid_trg_cnt == '0 && ext_trg_cnt == '0))
		else $error("counter not zero after reset");

	// selector moves only one step, and only after an update_end rise
	assert property (@(posedge clk_in) disable iff (rst_in)
		(hit_monit_sel != $past(hit_monit_sel)) |-> ($past(update_rise)
		&& hit_monit_sel == monit_types_pkg::hit_sel_t'($past(hit_monit_sel) + 1'b1)))
		else $error("hit_monit_sel moved without an update_end rise");

	// error counts held at zero during update_end
	assert property (@(posedge clk_in) disable iff (rst_in)
		update_end |=> (hit_monit_err_cnt == '0 && busy_monit_err_cnt == '0))
		else $error("error count changed while update_end high");

endmodule : hit_trg_count_sva

bind hit_trg_count hit_trg_count_sva i_sva (
	.clk_in             (clk_in),
	.rst_in             (rst_in),
	.update_end         (update_end),
	.update_rise        (update_rise),
	.hit_monit_sel      (hit_monit_sel),
	.hit_monit_err_cnt  (hit_monit_err_cnt),
	.busy_monit_err_cnt (busy_monit_err_cnt),
	.hit_monit_cnt_0    (hit_monit_cnt_0),
	.hit_monit_cnt_1    (hit_monit_cnt_1),
	.busy_monit_cnt     (busy_monit_cnt),
	.hit_start_cnt      (hit_start_cnt),
	.logic_match_cnt    (logic_match_cnt),
	.eff_trg_cnt        (eff_trg_cnt),
	.coincid_trg_cnt    (coincid_trg_cnt),
	.ext_trg_cnt        (ext_trg_cnt)
);

`default_nettype wire

// ==== design/hit_trg_count.sv ====
`timescale 1ns/1ps
`default_nettype none

module hit_trg_count (
	input  wire logic                               clk_in,
	input  wire logic                               rst_in,
	input  wire logic [monit_cfg_pkg::NUM_HIT-1:0]  hit_syn,
	input  wire logic [monit_cfg_pkg::NUM_BUSY-1:0] busy_syn,
	input  wire logic                               hit_start,
	input  wire logic                               update_end,  // register block done reading
	input  wire logic                               eff_trg,
	input  wire logic                               coincid_trg,
	input  wire logic                               logic_match,
	input  wire logic                               ext_trg_syn,
	input  wire monit_types_pkg::hit_sel_t          hit_monit_fix_sel,
	input  wire monit_types_pkg::busy_sel_t         busy_monit_fix_sel,
	output monit_types_pkg::hit_sel_t               hit_monit_sel,
	output monit_types_pkg::err_cnt_t               hit_monit_err_cnt,
	output monit_types_pkg::err_cnt_t               busy_monit_err_cnt,
	output monit_types_pkg::rate_cnt_t              hit_monit_cnt_0, // fixed hit line
	output monit_types_pkg::rate_cnt_t              hit_monit_cnt_1, // rotating hit line
	output monit_types_pkg::evt_cnt_t               busy_monit_cnt,
	output monit_types_pkg::evt_cnt_t               hit_start_cnt,
	output monit_types_pkg::evt_cnt_t               logic_match_cnt,
	output monit_types_pkg::evt_cnt_t               eff_trg_cnt,
	output monit_types_pkg::evt_cnt_t               coincid_trg_cnt,
	output monit_types_pkg::evt_cnt_t               ext_trg_cnt
);
	logic [monit_cfg_pkg::NUM_HIT-1:0]  hit_rise;
	logic [monit_cfg_pkg::NUM_BUSY-1:0] busy_rise;
	logic                               update_rise;

	pulse_mon_if #(.CNT_W(monit_cfg_pkg::EVT_CNT_W)) busy_if ();

	edge_event_counters i_edges (
		.clk_in          (clk_in),
		.rst_in          (rst_in),
		.hit_syn         (hit_syn),
		.busy_syn        (busy_syn),
		.update_end      (update_end),
		.hit_start       (hit_start),
		.coincid_trg     (coincid_trg),
		.logic_match     (logic_match),
		.ext_trg_syn     (ext_trg_syn),
		.hit_rise        (hit_rise),
		.busy_rise       (busy_rise),
		.update_rise     (update_rise),
		.hit_start_cnt   (hit_start_cnt),
		.coincid_trg_cnt (coincid_trg_cnt),
		.logic_match_cnt (logic_match_cnt),
		.ext_trg_cnt     (ext_trg_cnt)
	);

	hit_monit_group i_hit_grp (
		.clk_in        (clk_in),
		.rst_in        (rst_in),
		.hit_syn       (hit_syn),
		.hit_rise      (hit_rise),
		.update_end    (update_end),
		.update_rise   (update_rise),
		.fix_sel       (hit_monit_fix_sel),
		.hit_monit_sel (hit_monit_sel),
		.cnt_0         (hit_monit_cnt_0),
		.cnt_1         (hit_monit_cnt_1),
		.err_cnt       (hit_monit_err_cnt)
	);

	// busy side, one fixed line
	assign busy_if.level = busy_syn[busy_monit_fix_sel];
	assign busy_if.rise  = busy_rise[busy_monit_fix_sel];
	assign busy_if.clear = update_end;

	pulse_width_monitor #(
		.NOMINAL_WIDTH (monit_cfg_pkg::BUSY_WIDTH),
		.CNT_W         (monit_cfg_pkg::EVT_CNT_W)
	) i_busy_mon (
		.clk_in (clk_in),
		.rst_in (rst_in),
		.mon    (busy_if.mon)
	);

	assign busy_monit_cnt = busy_if.rate_cnt;

	sat_err_counter i_busy_err (
		.clk_in  (clk_in),
		.rst_in  (rst_in),
		.clear   (update_end),
		.inc     (busy_if.width_err),
		.err_cnt (busy_monit_err_cnt)
	);

	tmr_event_counter i_eff_trg (
		.clk_in (clk_in),
		.rst_in (rst_in),
		.inc    (eff_trg), // level count, every high cycle
		.cnt    (eff_trg_cnt)
	);

endmodule : hit_trg_count

`default_nettype wire

// ==== design/tmr_event_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module tmr_event_counter (
	input  wire logic                 clk_in,
	input  wire logic                 rst_in,
	input  wire logic                 inc,  // count this cycle
	output monit_types_pkg::evt_cnt_t cnt   // voted and registered, serves as trigger id
);
	monit_types_pkg::evt_cnt_t cnt_a;
	monit_types_pkg::evt_cnt_t cnt_b;
	monit_types_pkg::evt_cnt_t cnt_c;
	monit_types_pkg::evt_cnt_t voted;
	logic                      mismatch;

	assign voted    = (cnt_a & cnt_b) | (cnt_a & cnt_c) | (cnt_b & cnt_c); // bitwise 2 of 3
	assign mismatch = (cnt_a != cnt_b) || (cnt_a != cnt_c);

	always_ff @(posedge clk_in) begin
		if (rst_in) begin
			cnt_a <= '0;
			cnt_b <= '0;
			cnt_c <= '0;
		end else if (inc) begin
			cnt_a <= cnt_a + 1'b1; // copies step on their own
			cnt_b <= cnt_b + 1'b1;
			cnt_c <= cnt_c + 1'b1;
		end else if (mismatch) begin
			cnt_a <= voted; // scrub in an idle cycle
			cnt_b <= voted;
			cnt_c <= voted;
		end
	end

	always_ff @(posedge clk_in) begin
		if (rst_in) begin
			cnt <= '0;
		end else begin
			cnt <= voted; // extra stage keeps the voter off the output path
		end
	end

endmodule : tmr_event_counter

`default_nettype wire

// ==== design/hit_monit_group.sv ====
`timescale 1ns/1ps
`default_nettype none

module hit_monit_group (
	input  wire logic                              clk_in,
	input  wire logic                              rst_in,
	input  wire logic [monit_cfg_pkg::NUM_HIT-1:0] hit_syn,
	input  wire logic [monit_cfg_pkg::NUM_HIT-1:0] hit_rise,
	input  wire logic                              update_end,
	input  wire logic                              update_rise,
	input  wire monit_types_pkg::hit_sel_t         fix_sel,
	output monit_types_pkg::hit_sel_t              hit_monit_sel,
	output monit_types_pkg::rate_cnt_t             cnt_0,
	output monit_types_pkg::rate_cnt_t             cnt_1,
	output monit_types_pkg::err_cnt_t              err_cnt
);
	monit_types_pkg::hit_sel_t  line_sel [2]; // 0 fixed line, 1 rotating line
	monit_types_pkg::rate_cnt_t rate     [2];
	logic [1:0]                 err_flag;

	// rotating selector, moves on once the register block has read the window
	always_ff @(posedge clk_in) begin
		if (rst_in) begin
			hit_monit_sel <= '0;
		end else if (update_rise) begin
			hit_monit_sel <= hit_monit_sel + 1'b1; // wraps after 7
		end
	end

	assign line_sel[0] = fix_sel;
	assign line_sel[1] = hit_monit_sel;

	for (genvar i = 0; i < 2; i++) begin : g_mon
		pulse_mon_if #(.CNT_W(monit_cfg_pkg::RATE_CNT_W)) mon_if ();

		assign mon_if.level = hit_syn[line_sel[i]];
		assign mon_if.rise  = hit_rise[line_sel[i]];
		assign mon_if.clear = update_end;

		pulse_width_monitor #(
			.NOMINAL_WIDTH (monit_cfg_pkg::HIT_WIDTH),
			.CNT_W         (monit_cfg_pkg::RATE_CNT_W)
		) i_mon (
			.clk_in (clk_in),
			.rst_in (rst_in),
			.mon    (mon_if.mon)
		);

		assign err_flag[i] = mon_if.width_err;
		assign rate[i]     = mon_if.rate_cnt;
	end

	assign cnt_0 = rate[0];
	assign cnt_1 = rate[1];

	// same pulse on both monitors counts once
	sat_err_counter i_err_cnt (
		.clk_in  (clk_in),
		.rst_in  (rst_in),
		.clear   (update_end),
		.inc     (|err_flag),
		.err_cnt (err_cnt)
	);

endmodule : hit_monit_group

`default_nettype wire

// ==== design/sat_err_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module sat_err_counter (
	input  wire logic                 clk_in,
	input  wire logic                 rst_in,
	input  wire logic                 clear,  // update_end level
	input  wire logic                 inc,    // one error this cycle
	output monit_types_pkg::err_cnt_t err_cnt
);
	always_ff @(posedge clk_in) begin
		if (rst_in || clear) begin
			err_cnt <= '0;
		end else if (inc && (err_cnt != '1)) begin
			err_cnt <= err_cnt + 1'b1; // stops at all ones
		end
	end

endmodule : sat_err_counter

`default_nettype wire

// ==== design/pulse_width_monitor.sv ====
`timescale 1ns/1ps
`default_nettype none

module pulse_width_monitor #(
	parameter int NOMINAL_WIDTH = monit_cfg_pkg::HIT_WIDTH,  // shortest good pulse
	parameter int CNT_W         = monit_cfg_pkg::RATE_CNT_W  // rate counter width
) (
	input  wire logic clk_in,
	input  wire logic rst_in,
	pulse_mon_if.mon  mon
);
	monit_types_pkg::width_state_t state;
	monit_types_pkg::width_cnt_t   width_cnt; // high cycles seen before the current one
	logic                          err_q;
	logic [CNT_W-1:0]              rate_q;

	// rate counter, restarts with every update window
	always_ff @(posedge clk_in) begin
		if (rst_in) begin
			rate_q <= '0;
		end else if (mon.clear) begin
			rate_q <= '0;
		end else if (mon.rise) begin
			rate_q <= rate_q + 1'b1;
		end
	end

	// width check, good pulse is NOMINAL_WIDTH to NOMINAL_WIDTH + 3 cycles
	always_ff @(posedge clk_in) begin
		if (rst_in) begin
			state     <= monit_types_pkg::WIDTH_IDLE;
			width_cnt <= '0;
			err_q     <= 1'b0;
		end else begin
			err_q <= 1'b0; // flag lasts one cycle
			case (state)
				monit_types_pkg::WIDTH_IDLE: begin
					if (mon.rise && !mon.clear) begin // pulses opening under clear are ignored
						state     <= monit_types_pkg::WIDTH_CHECK;
						width_cnt <= monit_types_pkg::width_cnt_t'(1); // rise cycle is cycle 1
					end
				end
				monit_types_pkg::WIDTH_CHECK: begin
					if (mon.clear) begin
						state <= monit_types_pkg::WIDTH_IDLE; // window restarts, drop this pulse
					end else if (mon.level) begin
						if (width_cnt >= monit_types_pkg::width_cnt_t'(NOMINAL_WIDTH + 3)) begin
							err_q <= 1'b1; // one cycle past the window
							state <= monit_types_pkg::WIDTH_IDLE; // rest of pulse needs no rise
						end else begin
							width_cnt <= width_cnt + 1'b1;
						end
					end else begin
						// falling edge, width_cnt is the full pulse length
						err_q <= (width_cnt < monit_types_pkg::width_cnt_t'(NOMINAL_WIDTH));
						state <= monit_types_pkg::WIDTH_IDLE;
					end
				end
				default: state <= monit_types_pkg::WIDTH_IDLE;
			endcase
		end
	end

	assign mon.width_err = err_q;
	assign mon.rate_cnt  = rate_q;

endmodule : pulse_width_monitor

`default_nettype wire

// ==== design/edge_event_counters.sv ====
`timescale 1ns/1ps
`default_nettype none

module edge_event_counters (
	input  wire logic                               clk_in,
	input  wire logic                               rst_in,
	input  wire logic [monit_cfg_pkg::NUM_HIT-1:0]  hit_syn,
	input  wire logic [monit_cfg_pkg::NUM_BUSY-1:0] busy_syn,
	input  wire logic                               update_end,
	input  wire logic                               hit_start,
	input  wire logic                               coincid_trg,
	input  wire logic                               logic_match,
	input  wire logic                               ext_trg_syn,
	output logic [monit_cfg_pkg::NUM_HIT-1:0]       hit_rise,
	output logic [monit_cfg_pkg::NUM_BUSY-1:0]      busy_rise,
	output logic                                    update_rise,
	output monit_types_pkg::evt_cnt_t               hit_start_cnt,
	output monit_types_pkg::evt_cnt_t               coincid_trg_cnt,
	output monit_types_pkg::evt_cnt_t               logic_match_cnt,
	output monit_types_pkg::evt_cnt_t               ext_trg_cnt
);
	logic [monit_cfg_pkg::NUM_HIT-1:0]  hit_q;    // previous cycle of each hit line
	logic [monit_cfg_pkg::NUM_BUSY-1:0] busy_q;   // previous cycle of each busy line
	logic                               update_q; // previous update_end
	logic [3:0]                         evt_in;   // hit start, coincid, logic match, ext trg
	logic [3:0]                         evt_q;
	logic [3:0]                         evt_rise;
	monit_types_pkg::evt_cnt_t          evt_cnt [4];

	assign evt_in      = {ext_trg_syn, logic_match, coincid_trg, hit_start};
	assign evt_rise    = evt_in & ~evt_q;
	assign hit_rise    = hit_syn & ~hit_q;     // high now, low last cycle
	assign busy_rise   = busy_syn & ~busy_q;
	assign update_rise = update_end & ~update_q;

	always_ff @(posedge clk_in) begin
		if (rst_in) begin
			hit_q    <= '0;
			busy_q   <= '0;
			update_q <= 1'b0;
			evt_q    <= '0;
			for (int i = 0; i < 4; i++) begin
				evt_cnt[i] <= '0;
			end
		end else begin
			hit_q    <= hit_syn;
			busy_q   <= busy_syn;
			update_q <= update_end;
			evt_q    <= evt_in;
			for (int i = 0; i < 4; i++) begin
				if (evt_rise[i]) begin
					evt_cnt[i] <= evt_cnt[i] + 1'b1; // wraps at 16 bits
				end
			end
		end
	end

	assign hit_start_cnt   = evt_cnt[0];
	assign coincid_trg_cnt = evt_cnt[1];
	assign logic_match_cnt = evt_cnt[2];
	assign ext_trg_cnt     = evt_cnt[3];

endmodule : edge_event_counters

`default_nettype wire

// ==== design/pulse_mon_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface pulse_mon_if #(
	parameter int CNT_W = 32 // rate counter width on the mon side
);
	logic             level;     // selected line, high while the pulse lasts
	logic             rise;      // first high cycle of that line
	logic             clear;     // update_end level, restarts the window
	logic             width_err; // one cycle per bad pulse
	logic [CNT_W-1:0] rate_cnt;  // pulses seen since the last clear

	modport src (output level, rise, clear, input width_err, rate_cnt);
	modport mon (input level, rise, clear, output width_err, rate_cnt);

endinterface : pulse_mon_if

`default_nettype wire

// ==== design/monit_types_pkg.sv ====
`default_nettype none

package monit_types_pkg;

	// channel selects
	typedef logic [$clog2(monit_cfg_pkg::NUM_HIT)-1:0]  hit_sel_t;  // 3 bits for 8 lines
	typedef logic [$clog2(monit_cfg_pkg::NUM_BUSY)-1:0] busy_sel_t; // 1 bit for 2 lines

	// counts
	typedef logic [monit_cfg_pkg::EVT_CNT_W-1:0]   evt_cnt_t;   // wraps at 2^16
	typedef logic [monit_cfg_pkg::RATE_CNT_W-1:0]  rate_cnt_t;  // per-window hit rate
	typedef logic [monit_cfg_pkg::ERR_CNT_W-1:0]   err_cnt_t;   // saturates at 255
	typedef logic [monit_cfg_pkg::WIDTH_CNT_W-1:0] width_cnt_t; // high cycles of one pulse

	// width check fsm
	typedef enum logic {
		WIDTH_IDLE  = 1'b0, // waiting for a rise
		WIDTH_CHECK = 1'b1  // timing an open pulse
	} width_state_t;

endpackage : monit_types_pkg

`default_nettype wire

// ==== design/monit_cfg_pkg.sv ====
`default_nettype none

package monit_cfg_pkg;

	// front end line counts
	localparam int NUM_HIT  = 8; // synchronized hit lines
	localparam int NUM_BUSY = 2; // synchronized busy lines

	// nominal pulse widths in 50 MHz cycles, 160 ns
	localparam int HIT_WIDTH  = 8; // good hit pulse is 8 to 11 cycles
	localparam int BUSY_WIDTH = 8; // same window for busy

	// counter widths
	localparam int RATE_CNT_W  = 32; // hit rate counters
	localparam int EVT_CNT_W   = 16; // event counters and busy rate
	localparam int ERR_CNT_W   = 8;  // saturating error counters
	localparam int WIDTH_CNT_W = 4;  // pulse length, must hold HIT_WIDTH + 3

endpackage : monit_cfg_pkg

`default_nettype wire
